//--- verilog/typewriter_pkg.sv
/*
 * Shared definitions for the console typewriter control: widths, cam contact
 * windows, operation and cam state enums, contact and status structs, relay slots
 */
package typewriter_pkg;

    // Cam angle in degrees, 0 to 359
    typedef logic [8:0] cam_angle_t;

    localparam int unsigned CAM_DEGREES = 360;

    // Contact windows, both ends closed
    localparam cam_angle_t CRCB1_START = 9'd0;
    localparam cam_angle_t CRCB1_END   = 9'd50;
    localparam cam_angle_t CRCB2_START = 9'd50;
    localparam cam_angle_t CRCB2_END   = 9'd99;
    localparam cam_angle_t CRCB3_START = 9'd99;
    localparam cam_angle_t CRCB3_END   = 9'd308;
    localparam cam_angle_t CRCB4_START = 9'd171;
    localparam cam_angle_t CRCB4_END   = 9'd220;
    localparam cam_angle_t CRCB5_START = 9'd220;
    localparam cam_angle_t CRCB5_END   = 9'd299;
    localparam cam_angle_t CRCB6_START = 9'd310;
    localparam cam_angle_t CRCB6_END   = 9'd359;

    // Typewriter character code
    typedef logic [5:0] tw_char_t;

    localparam int TW_UPPER_BIT = 5;

    typedef enum logic {
        WRITE_NUM   = 1'b0,
        WRITE_ALPHA = 1'b1
    } op_code_t;

    typedef enum logic {
        CAM_IDLE = 1'b0,
        CAM_TURN = 1'b1
    } cam_state_t;

    typedef struct packed {
        logic crcb_1;
        logic crcb_2;
        logic crcb_3;
        logic crcb_4;
        logic crcb_5;
        logic crcb_6;
    } cam_contacts_t;

    typedef struct packed {
        logic wr_num_status;
        logic wr_alpha_status;
        logic shift;
        logic flag_intlk;
        logic wr_intlk;
    } tw_status_t;

    // Relay slots inside the duo and latching banks
    localparam int DUO_WR_NUM     = 0;
    localparam int DUO_WR_ALPHA   = 1;
    localparam int LATCH_WR_INTLK = 0;
    localparam int LATCH_SHIFT    = 1;
    localparam int LATCH_FLAG     = 2;

endpackage

//--- verilog/cam_timer.sv
`timescale 1ns/1ps
/*
 * Print cam timer: idle/turning FSM, angle counter stepping one degree
 * per clock, and the six cam contacts decoded from their windows
 */
module cam_timer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cam_start,
    output typewriter_pkg::cam_contacts_t contacts,
    output logic                          cam_busy,
    output logic                          cam_done
);

    localparam typewriter_pkg::cam_angle_t LAST_ANGLE =
        typewriter_pkg::cam_angle_t'(typewriter_pkg::CAM_DEGREES - 1);

    typewriter_pkg::cam_state_t state;
    typewriter_pkg::cam_angle_t angle;

    function automatic logic in_window(
        input typewriter_pkg::cam_angle_t a,
        input typewriter_pkg::cam_angle_t lo,
        input typewriter_pkg::cam_angle_t hi
    );
        return (a >= lo) && (a <= hi);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= typewriter_pkg::CAM_IDLE;
            angle <= '0;
        end else begin
            case (state)
                typewriter_pkg::CAM_IDLE: begin
                    angle <= '0;
                    if (cam_start) begin
                        state <= typewriter_pkg::CAM_TURN;
                    end
                end
                typewriter_pkg::CAM_TURN: begin
                    // Full turn done, park at zero
                    if (cam_done) begin
                        state <= typewriter_pkg::CAM_IDLE;
                        angle <= '0;
                    end else begin
                        angle <= angle + 9'd1;
                    end
                end
                default: begin
                    state <= typewriter_pkg::CAM_IDLE;
                    angle <= '0;
                end
            endcase
        end
    end

    assign cam_busy = (state == typewriter_pkg::CAM_TURN);
    assign cam_done = cam_busy && (angle == LAST_ANGLE);

    // Contacts only close while the cam is turning
    always_comb begin
        contacts = '0;
        if (cam_busy) begin
            contacts.crcb_1 = in_window(angle, typewriter_pkg::CRCB1_START,
                                        typewriter_pkg::CRCB1_END);
            contacts.crcb_2 = in_window(angle, typewriter_pkg::CRCB2_START,
                                        typewriter_pkg::CRCB2_END);
            contacts.crcb_3 = in_window(angle, typewriter_pkg::CRCB3_START,
                                        typewriter_pkg::CRCB3_END);
            contacts.crcb_4 = in_window(angle, typewriter_pkg::CRCB4_START,
                                        typewriter_pkg::CRCB4_END);
            contacts.crcb_5 = in_window(angle, typewriter_pkg::CRCB5_START,
                                        typewriter_pkg::CRCB5_END);
            contacts.crcb_6 = in_window(angle, typewriter_pkg::CRCB6_START,
                                        typewriter_pkg::CRCB6_END);
        end
    end

endmodule

//--- verilog/relay_bank.sv
`timescale 1ns/1ps
/*
 * Relay bank: duo relays (pick or hold coil) and latching relays
 * (pick and trip coils), each armature held in a register
 */
module relay_bank #(
    parameter int DUO_COUNT   = 2,
    parameter int LATCH_COUNT = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [DUO_COUNT-1:0]   duo_pick,
    input  logic [DUO_COUNT-1:0]   duo_hold,
    input  logic [LATCH_COUNT-1:0] latch_pick,
    input  logic [LATCH_COUNT-1:0] latch_trip,
    output logic [DUO_COUNT-1:0]   duo_state,
    output logic [LATCH_COUNT-1:0] latch_state
);

    // Duo relay drops as soon as neither coil is energized
    always_ff @(posedge clk) begin
        if (rst) begin
            duo_state <= '0;
        end else begin
            duo_state <= duo_pick | duo_hold;
        end
    end

    // Latching relay stays put until tripped, pick coil dominates
    always_ff @(posedge clk) begin
        if (rst) begin
            latch_state <= '0;
        end else begin
            latch_state <= latch_pick | (latch_state & ~latch_trip);
        end
    end

endmodule

//--- verilog/typewriter_control.sv
`timescale 1ns/1ps
/*
 * Typewriter control: operation capture, relay pick/hold/trip decisions,
 * print magnet strobe and mapping of relay contacts to status
 */
module typewriter_control #(
    parameter int DUO_COUNT   = 2,
    parameter int LATCH_COUNT = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          go,
    input  typewriter_pkg::op_code_t      op,
    input  typewriter_pkg::tw_char_t      char_in,
    input  logic                          flag_in,
    input  typewriter_pkg::cam_contacts_t contacts,
    input  logic                          cam_busy,
    input  logic                          cam_done,
    input  logic [DUO_COUNT-1:0]          duo_state,
    input  logic [LATCH_COUNT-1:0]        latch_state,
    output logic                          cam_start,
    output logic [DUO_COUNT-1:0]          duo_pick,
    output logic [DUO_COUNT-1:0]          duo_hold,
    output logic [LATCH_COUNT-1:0]        latch_pick,
    output logic [LATCH_COUNT-1:0]        latch_trip,
    output logic                          busy,
    output logic                          print_valid,
    output typewriter_pkg::tw_char_t      print_char,
    output typewriter_pkg::tw_status_t    status
);

    logic                     accept;
    logic                     keep_duo;
    logic                     crcb_4_prev;
    typewriter_pkg::op_code_t op_q;
    typewriter_pkg::tw_char_t char_q;
    logic                     flag_q;

    // No queue, a go while busy is simply dropped
    assign busy   = latch_state[typewriter_pkg::LATCH_WR_INTLK] | cam_start;
    assign accept = go && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            cam_start   <= 1'b0;
            crcb_4_prev <= 1'b0;
        end else begin
            cam_start   <= accept;
            crcb_4_prev <= contacts.crcb_4;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op;
            char_q <= char_in;
            flag_q <= flag_in;
        end
    end

    // Duo hold path runs through the relay's own contact
    assign keep_duo = cam_start || (cam_busy && !cam_done);

    always_comb begin
        duo_pick   = '0;
        latch_pick = '0;
        latch_trip = '0;
        duo_hold   = duo_state & {DUO_COUNT{keep_duo}};

        duo_pick[typewriter_pkg::DUO_WR_NUM] =
            accept && (op == typewriter_pkg::WRITE_NUM);
        duo_pick[typewriter_pkg::DUO_WR_ALPHA] =
            accept && (op == typewriter_pkg::WRITE_ALPHA);

        latch_pick[typewriter_pkg::LATCH_WR_INTLK] = accept;
        latch_trip[typewriter_pkg::LATCH_WR_INTLK] = cam_done;

        // Upper case alpha shifts early in the turn
        latch_pick[typewriter_pkg::LATCH_SHIFT] = contacts.crcb_1
            && (op_q == typewriter_pkg::WRITE_ALPHA)
            && char_q[typewriter_pkg::TW_UPPER_BIT];
        latch_trip[typewriter_pkg::LATCH_SHIFT] = contacts.crcb_6;

        latch_pick[typewriter_pkg::LATCH_FLAG] = contacts.crcb_2 && flag_q;
        latch_trip[typewriter_pkg::LATCH_FLAG] = cam_done;
    end

    // Print magnet fires as contact 4 makes
    assign print_valid = contacts.crcb_4 && !crcb_4_prev;
    assign print_char  = char_q;

    always_comb begin
        status.wr_num_status   = duo_state[typewriter_pkg::DUO_WR_NUM];
        status.wr_alpha_status = duo_state[typewriter_pkg::DUO_WR_ALPHA];
        status.shift           = latch_state[typewriter_pkg::LATCH_SHIFT];
        status.flag_intlk      = latch_state[typewriter_pkg::LATCH_FLAG];
        status.wr_intlk        = latch_state[typewriter_pkg::LATCH_WR_INTLK];
    end

endmodule

//--- verilog/typewriter.sv
`timescale 1ns/1ps
/*
 * Console typewriter top level: control, print cam timer and relay bank
 */
module typewriter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       go,
    input  typewriter_pkg::op_code_t   op,
    input  typewriter_pkg::tw_char_t   char_in,
    input  logic                       flag_in,
    output logic                       busy,
    output logic                       print_valid,
    output typewriter_pkg::tw_char_t   print_char,
    output typewriter_pkg::tw_status_t status
);

    // Two duo relays, three latching relays
    localparam int DUO_COUNT   = 2;
    localparam int LATCH_COUNT = 3;

    logic                          cam_start;
    logic                          cam_busy;
    logic                          cam_done;
    typewriter_pkg::cam_contacts_t contacts;
    logic [DUO_COUNT-1:0]          duo_pick;
    logic [DUO_COUNT-1:0]          duo_hold;
    logic [DUO_COUNT-1:0]          duo_state;
    logic [LATCH_COUNT-1:0]        latch_pick;
    logic [LATCH_COUNT-1:0]        latch_trip;
    logic [LATCH_COUNT-1:0]        latch_state;

    typewriter_control #(
        .DUO_COUNT   (DUO_COUNT),
        .LATCH_COUNT (LATCH_COUNT)
    ) u_control (
        .clk         (clk),
        .rst         (rst),
        .go          (go),
        .op          (op),
        .char_in     (char_in),
        .flag_in     (flag_in),
        .contacts    (contacts),
        .cam_busy    (cam_busy),
        .cam_done    (cam_done),
        .duo_state   (duo_state),
        .latch_state (latch_state),
        .cam_start   (cam_start),
        .duo_pick    (duo_pick),
        .duo_hold    (duo_hold),
        .latch_pick  (latch_pick),
        .latch_trip  (latch_trip),
        .busy        (busy),
        .print_valid (print_valid),
        .print_char  (print_char),
        .status      (status)
    );

    cam_timer u_cam (
        .clk       (clk),
        .rst       (rst),
        .cam_start (cam_start),
        .contacts  (contacts),
        .cam_busy  (cam_busy),
        .cam_done  (cam_done)
    );

    relay_bank #(
        .DUO_COUNT   (DUO_COUNT),
        .LATCH_COUNT (LATCH_COUNT)
    ) u_relays (
        .clk         (clk),
        .rst         (rst),
        .duo_pick    (duo_pick),
        .duo_hold    (duo_hold),
        .latch_pick  (latch_pick),
        .latch_trip  (latch_trip),
        .duo_state   (duo_state),
        .latch_state (latch_state)
    );

endmodule

//--- testbench/typewriter_tb.sv
`timescale 1ns/1ps
/*
 * Testbench for the console typewriter: clock, reset, pattern file reading,
 * stimulus with ignored go pulses, compare tasks, watchdog and summary
 */
module typewriter_tb;

    localparam int RANDOM_OPS    = 4;
    localparam int PRINT_CYCLE   = 172;
    localparam int DONE_CYCLE    = 361;
    localparam int POKE_CYCLE    = 100;
    localparam int CYCLES_PER_OP = 400;

    logic                       clk;
    logic                       rst;
    logic                       go;
    typewriter_pkg::op_code_t   op;
    typewriter_pkg::tw_char_t   char_in;
    logic                       flag_in;
    logic                       busy;
    logic                       print_valid;
    typewriter_pkg::tw_char_t   print_char;
    typewriter_pkg::tw_status_t status;

    int          value_errors;
    int          event_errors;
    int          pattern_count;
    int          i;
    logic        patterns_loaded;
    integer      seed;
    logic [31:0] rnd;

    typewriter_pkg::op_code_t pat_op[$];
    logic                     pat_flag[$];
    typewriter_pkg::tw_char_t pat_char[$];

    typewriter uut (
        .clk         (clk),
        .rst         (rst),
        .go          (go),
        .op          (op),
        .char_in     (char_in),
        .flag_in     (flag_in),
        .busy        (busy),
        .print_valid (print_valid),
        .print_char  (print_char),
        .status      (status)
    );

    always #50 clk = ~clk;

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors = value_errors + 1;
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_char(
        input string                    name,
        input typewriter_pkg::tw_char_t exp,
        input typewriter_pkg::tw_char_t act
    );
        if (act !== exp) begin
            value_errors = value_errors + 1;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_status(
        input string                      name,
        input typewriter_pkg::tw_status_t exp,
        input typewriter_pkg::tw_status_t act
    );
        if (act !== exp) begin
            value_errors = value_errors + 1;
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // Inputs change and outputs are read 5 ns after each rising edge
    task automatic step_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic read_patterns();
        integer     fd;
        integer     fields;
        string      line;
        logic [7:0] f_op;
        logic [7:0] f_flag;
        logic [7:0] f_char;
        fd = $fopen("testbench/typewriter_patterns.txt", "r");
        if (fd == 0) begin
            event_errors = event_errors + 1;
            $display("Could not open the pattern file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h", f_op, f_flag, f_char);
                    if (fields == 3) begin
                        pat_op.push_back(typewriter_pkg::op_code_t'(f_op[0]));
                        pat_flag.push_back(f_flag[0]);
                        pat_char.push_back(f_char[5:0]);
                    end
                end
            end
            $fclose(fd);
        end
        pattern_count = pat_op.size();
    endtask

    // One full cam turn, optionally with a go pulse while busy
    task automatic run_op(
        input typewriter_pkg::op_code_t o,
        input logic                     f,
        input typewriter_pkg::tw_char_t c,
        input logic                     poke_busy
    );
        typewriter_pkg::tw_status_t exp_status;
        int                         prints;
        int                         waited;
        int                         k;
        prints = 0;
        waited = 0;
        exp_status.wr_num_status   = (o == typewriter_pkg::WRITE_NUM);
        exp_status.wr_alpha_status = (o == typewriter_pkg::WRITE_ALPHA);
        exp_status.shift           = (o == typewriter_pkg::WRITE_ALPHA) && c[5];
        exp_status.flag_intlk      = f;
        exp_status.wr_intlk        = 1'b1;
        while (busy && waited < CYCLES_PER_OP) begin
            step_cycle();
            waited = waited + 1;
        end
        if (busy) begin
            event_errors = event_errors + 1;
            $display("busy never dropped, operation could not be started");
        end
        go      = 1'b1;
        op      = o;
        char_in = c;
        flag_in = f;
        step_cycle();
        go = 1'b0;
        check_bit("busy", 1'b1, busy);
        for (k = 1; k <= DONE_CYCLE + 1; k = k + 1) begin
            if (poke_busy && k == POKE_CYCLE) begin
                go      = 1'b1;
                op      = (o == typewriter_pkg::WRITE_NUM) ? typewriter_pkg::WRITE_ALPHA
                                                           : typewriter_pkg::WRITE_NUM;
                char_in = ~c;
                flag_in = ~f;
            end else begin
                go = 1'b0;
            end
            step_cycle();
            if (print_valid === 1'b1) begin
                prints = prints + 1;
            end
            check_bit("print_valid", k == PRINT_CYCLE, print_valid);
            check_bit("busy", k < DONE_CYCLE, busy);
            if (k == PRINT_CYCLE) begin
                check_char("print_char", c, print_char);
                check_status("status", exp_status, status);
            end
            if (k == DONE_CYCLE) begin
                check_status("status", '0, status);
            end
        end
        if (prints != 1) begin
            event_errors = event_errors + 1;
            $display("Operation with char %h gave %0d print pulses instead of one", c, prints);
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        go              = 1'b0;
        op              = typewriter_pkg::WRITE_NUM;
        char_in         = '0;
        flag_in         = 1'b0;
        value_errors    = 0;
        event_errors    = 0;
        pattern_count   = 0;
        patterns_loaded = 1'b0;
        seed            = 32'h8c5663d7;
        read_patterns();
        patterns_loaded = 1'b1;
        if (pattern_count == 0) begin
            event_errors = event_errors + 1;
            $display("No operations found in the pattern file");
        end
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;
        check_bit("busy", 1'b0, busy);
        check_bit("print_valid", 1'b0, print_valid);
        check_status("status", '0, status);
        for (i = 0; i < pattern_count; i = i + 1) begin
            run_op(pat_op[i], pat_flag[i], pat_char[i], (i % 3) == 2);
        end
        for (i = 0; i < RANDOM_OPS; i = i + 1) begin
            rnd = $random(seed);
            run_op(typewriter_pkg::op_code_t'(rnd[8]), rnd[12], rnd[5:0], 1'b1);
        end
        step_cycle();
        $display("Summary: %0d value errors, %0d other errors", value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Budget of 400 cycles per operation plus two for reset and wind down
    initial begin
        wait (patterns_loaded);
        repeat ((pattern_count + RANDOM_OPS + 2) * CYCLES_PER_OP) @(posedge clk);
        $display("Timeout, the run hung and the watchdog stopped it");
        $display("Something failed");
        $finish;
    end

endmodule

//--- testbench/typewriter_patterns.txt
# Columns in hex: op (0 write numeric, 1 write alphameric), flag bit, character
# Character bit 5 is the upper-case bit
0 0 01
0 1 09
1 0 21
1 1 3f
0 0 20
1 0 15
1 1 2a
0 1 00
1 0 3c
0 0 12
1 1 07
1 0 30
0 1 2f
1 1 11
0 0 3e
1 0 2b
0 1 18
1 1 33
0 0 05
1 0 1e
1 1 26
0 0 3a

//--- list.f
verilog/typewriter_pkg.sv
verilog/cam_timer.sv
verilog/relay_bank.sv
verilog/typewriter_control.sv
verilog/typewriter.sv
testbench/typewriter_tb.sv

//--- Makefile
# Verilator build and run of the console typewriter testbench
VERILATOR ?= verilator
TOP       ?= typewriter_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Everything OK

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
